// ==== design/ooo_exec_pkg.sv ====
package ooo_exec_pkg;

  // opcode codes, shared with the stimulus file
  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_OR    = 4'd3,
    OP_XOR   = 4'd4,
    OP_SLL   = 4'd5,
    OP_SRL   = 4'd6,
    OP_SLT   = 4'd7,
    OP_MUL   = 4'd8,
    OP_MULHU = 4'd9,
    OP_DIVU  = 4'd10,
    OP_REMU  = 4'd11
  } exec_op_t;

  // operand and result value
  typedef logic [31:0] word_t;

  // destination register index
  typedef logic [4:0] reg_idx_t;

  // default completion buffer depth
  parameter int DEF_CB_ENTRIES = 8;

  // multiplier latency, pipeline is written for exactly three stages
  parameter int MUL_STAGES = 3;

endpackage

// ==== design/issue_unit.sv ====
module issue_unit #(
  parameter int CB_ENTRIES = 8
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          issue_valid,
  input  ooo_exec_pkg::exec_op_t        issue_op,
  input  ooo_exec_pkg::reg_idx_t        issue_rd,
  input  ooo_exec_pkg::word_t           issue_a,
  input  ooo_exec_pkg::word_t           issue_b,
  input  logic                          full,
  input  logic [$clog2(CB_ENTRIES)-1:0] alloc_tag,
  input  logic                          div_busy,
  output logic                          issue_ready,
  output logic                          alloc,
  output logic                          mul_start,
  output logic                          div_start,
  output ooo_exec_pkg::exec_op_t        unit_op,
  output ooo_exec_pkg::word_t           unit_a,
  output ooo_exec_pkg::word_t           unit_b,
  output logic [$clog2(CB_ENTRIES)-1:0] unit_tag,
  output ooo_exec_pkg::reg_idx_t        unit_rd,
  output logic                          alu_wr_valid,
  output logic [$clog2(CB_ENTRIES)-1:0] alu_wr_tag,
  output ooo_exec_pkg::reg_idx_t        alu_wr_rd,
  output ooo_exec_pkg::word_t           alu_wr_data
);
  import ooo_exec_pkg::*;

  logic  is_mul;
  logic  is_div;
  logic  accept;
  logic  ready_en;
  word_t alu_res;

  // unit select from opcode, anything else is alu
  assign is_mul = (issue_op == OP_MUL) || (issue_op == OP_MULHU);
  assign is_div = (issue_op == OP_DIVU) || (issue_op == OP_REMU);

  // goes high one cycle after reset release
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ready_en <= 1'b0;
    end else begin
      ready_en <= 1'b1;
    end
  end

  // stall on full buffer, or a divide while the divider works
  assign issue_ready = ready_en && !full && !(is_div && div_busy);
  assign accept      = issue_valid && issue_ready;

  assign alloc     = accept;
  assign mul_start = accept && is_mul;
  assign div_start = accept && is_div;

  // operands go to all units, start picks the one that takes them
  assign unit_op  = issue_op;
  assign unit_a   = issue_a;
  assign unit_b   = issue_b;
  assign unit_tag = alloc_tag;
  assign unit_rd  = issue_rd;

  always_comb begin
    case (issue_op)
      OP_ADD:  alu_res = issue_a + issue_b;
      OP_SUB:  alu_res = issue_a - issue_b;
      OP_AND:  alu_res = issue_a & issue_b;
      OP_OR:   alu_res = issue_a | issue_b;
      OP_XOR:  alu_res = issue_a ^ issue_b;
      // shift amount from low 5 bits only
      OP_SLL:  alu_res = issue_a << issue_b[4:0];
      OP_SRL:  alu_res = issue_a >> issue_b[4:0];
      OP_SLT:  alu_res = {31'd0, $signed(issue_a) < $signed(issue_b)};
      default: alu_res = '0;
    endcase
  end

  // single alu result stage, writes the buffer one cycle after accept
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      alu_wr_valid <= 1'b0;
    end else begin
      alu_wr_valid <= accept && !is_mul && !is_div;
    end
  end

  always_ff @(posedge CLK) begin
    alu_wr_tag  <= alloc_tag;
    alu_wr_rd   <= issue_rd;
    alu_wr_data <= alu_res;
  end

endmodule

// ==== design/mul_pipe.sv ====
module mul_pipe #(
  parameter int CB_ENTRIES = 8
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          mul_start,
  input  ooo_exec_pkg::exec_op_t        unit_op,
  input  ooo_exec_pkg::word_t           unit_a,
  input  ooo_exec_pkg::word_t           unit_b,
  input  logic [$clog2(CB_ENTRIES)-1:0] unit_tag,
  input  ooo_exec_pkg::reg_idx_t        unit_rd,
  output logic                          mul_wr_valid,
  output logic [$clog2(CB_ENTRIES)-1:0] mul_wr_tag,
  output ooo_exec_pkg::reg_idx_t        mul_wr_rd,
  output ooo_exec_pkg::word_t           mul_wr_data
);
  import ooo_exec_pkg::*;

  localparam int TAG_W = $clog2(CB_ENTRIES);

  logic [MUL_STAGES-1:0] v_pipe;
  logic [TAG_W-1:0]      tag_pipe [MUL_STAGES];
  reg_idx_t              rd_pipe  [MUL_STAGES];
  word_t                 s1_a;
  word_t                 s1_b;
  logic                  s1_hi;
  logic [63:0]           s2_prod;
  logic                  s2_hi;
  word_t                 s3_data;

  // valid walks the stages, no stall
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      v_pipe <= '0;
    end else begin
      v_pipe <= {v_pipe[MUL_STAGES-2:0], mul_start};
    end
  end

  // tag and destination ride alongside the data
  always_ff @(posedge CLK) begin
    tag_pipe[0] <= unit_tag;
    rd_pipe[0]  <= unit_rd;
    for (int i = 1; i < MUL_STAGES; i++) begin
      tag_pipe[i] <= tag_pipe[i-1];
      rd_pipe[i]  <= rd_pipe[i-1];
    end
  end

  always_ff @(posedge CLK) begin
    // stage 1: operands in
    s1_a    <= unit_a;
    s1_b    <= unit_b;
    s1_hi   <= (unit_op == OP_MULHU);
    // stage 2: full unsigned product
    s2_prod <= {32'd0, s1_a} * {32'd0, s1_b};
    s2_hi   <= s1_hi;
    // stage 3: pick half
    s3_data <= s2_hi ? s2_prod[63:32] : s2_prod[31:0];
  end

  assign mul_wr_valid = v_pipe[MUL_STAGES-1];
  assign mul_wr_tag   = tag_pipe[MUL_STAGES-1];
  assign mul_wr_rd    = rd_pipe[MUL_STAGES-1];
  assign mul_wr_data  = s3_data;

endmodule

// ==== design/div_unit.sv ====
module div_unit #(
  parameter int CB_ENTRIES = 8
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          div_start,
  input  ooo_exec_pkg::exec_op_t        unit_op,
  input  ooo_exec_pkg::word_t           unit_a,
  input  ooo_exec_pkg::word_t           unit_b,
  input  logic [$clog2(CB_ENTRIES)-1:0] unit_tag,
  input  ooo_exec_pkg::reg_idx_t        unit_rd,
  output logic                          div_busy,
  output logic                          div_wr_valid,
  output logic [$clog2(CB_ENTRIES)-1:0] div_wr_tag,
  output ooo_exec_pkg::reg_idx_t        div_wr_rd,
  output ooo_exec_pkg::word_t           div_wr_data
);
  import ooo_exec_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } div_state_t;

  div_state_t                    state;
  logic [4:0]                    step;
  word_t                         divisor;
  word_t                         quo;
  word_t                         rem;
  logic                          want_rem;
  logic [$clog2(CB_ENTRIES)-1:0] tag_q;
  reg_idx_t                      rd_q;
  logic [32:0]                   rem_sh;
  logic [32:0]                   diff;

  // one restoring step: shift next dividend bit in, try subtract
  assign rem_sh = {rem, quo[31]};
  assign diff   = rem_sh - {1'b0, divisor};

  // fsm, a new divide may load straight out of DONE
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE, DONE: begin
          state <= div_start ? RUN : IDLE;
          step  <= '0;
        end
        RUN: begin
          step <= step + 5'd1;
          if (step == 5'd31) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state != RUN && div_start) begin
      // quo starts as the dividend and shifts out as bits come in
      quo      <= unit_a;
      rem      <= '0;
      divisor  <= unit_b;
      want_rem <= (unit_op == OP_REMU);
      tag_q    <= unit_tag;
      rd_q     <= unit_rd;
    end else if (state == RUN) begin
      // borrow in bit 32 means the divisor did not fit
      if (!diff[32]) begin
        rem <= diff[31:0];
        quo <= {quo[30:0], 1'b1};
      end else begin
        rem <= rem_sh[31:0];
        quo <= {quo[30:0], 1'b0};
      end
    end
  end

  // divide by zero falls out as all-ones quotient, remainder = dividend
  assign div_busy     = (state == RUN);
  assign div_wr_valid = (state == DONE);
  assign div_wr_tag   = tag_q;
  assign div_wr_rd    = rd_q;
  assign div_wr_data  = want_rem ? rem : quo;

endmodule

// ==== design/completion_buffer.sv ====
module completion_buffer #(
  parameter int CB_ENTRIES = 8
) (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          alloc,
  input  logic                          pop,
  input  logic                          alu_wr_valid,
  input  logic [$clog2(CB_ENTRIES)-1:0] alu_wr_tag,
  input  ooo_exec_pkg::reg_idx_t        alu_wr_rd,
  input  ooo_exec_pkg::word_t           alu_wr_data,
  input  logic                          mul_wr_valid,
  input  logic [$clog2(CB_ENTRIES)-1:0] mul_wr_tag,
  input  ooo_exec_pkg::reg_idx_t        mul_wr_rd,
  input  ooo_exec_pkg::word_t           mul_wr_data,
  input  logic                          div_wr_valid,
  input  logic [$clog2(CB_ENTRIES)-1:0] div_wr_tag,
  input  ooo_exec_pkg::reg_idx_t        div_wr_rd,
  input  ooo_exec_pkg::word_t           div_wr_data,
  output logic                          full,
  output logic [$clog2(CB_ENTRIES)-1:0] alloc_tag,
  output logic                          head_done,
  output ooo_exec_pkg::reg_idx_t        head_rd,
  output ooo_exec_pkg::word_t           head_data
);
  import ooo_exec_pkg::*;

  localparam int TAG_W = $clog2(CB_ENTRIES);

  logic [CB_ENTRIES-1:0] ent_busy;
  logic [CB_ENTRIES-1:0] ent_done;
  reg_idx_t              ent_rd   [CB_ENTRIES];
  word_t                 ent_data [CB_ENTRIES];
  logic [TAG_W-1:0]      head;
  logic [TAG_W-1:0]      tail;
  logic [TAG_W:0]        count;

  // pointers wrap on their own at a power-of-two depth
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + TAG_W'(1);
      end
      if (pop) begin
        head <= head + TAG_W'(1);
      end
      count <= count + (TAG_W+1)'(alloc) - (TAG_W+1)'(pop);
    end
  end

  // alloc and pop never hit the same slot
  // alloc needs room and pop needs a finished head
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ent_busy <= '0;
      ent_done <= '0;
    end else begin
      if (alloc) begin
        ent_busy[tail] <= 1'b1;
        ent_done[tail] <= 1'b0;
      end
      // distinct tags in flight keep the ports apart
      if (alu_wr_valid) begin
        ent_done[alu_wr_tag] <= 1'b1;
      end
      if (mul_wr_valid) begin
        ent_done[mul_wr_tag] <= 1'b1;
      end
      if (div_wr_valid) begin
        ent_done[div_wr_tag] <= 1'b1;
      end
      if (pop) begin
        ent_busy[head] <= 1'b0;
        ent_done[head] <= 1'b0;
      end
    end
  end

  // result storage
  always_ff @(posedge CLK) begin
    if (alu_wr_valid) begin
      ent_rd[alu_wr_tag]   <= alu_wr_rd;
      ent_data[alu_wr_tag] <= alu_wr_data;
    end
    if (mul_wr_valid) begin
      ent_rd[mul_wr_tag]   <= mul_wr_rd;
      ent_data[mul_wr_tag] <= mul_wr_data;
    end
    if (div_wr_valid) begin
      ent_rd[div_wr_tag]   <= div_wr_rd;
      ent_data[div_wr_tag] <= div_wr_data;
    end
  end

  assign full      = (count == (TAG_W+1)'(CB_ENTRIES));
  assign alloc_tag = tail;
  assign head_done = ent_busy[head] && ent_done[head];
  assign head_rd   = ent_rd[head];
  assign head_data = ent_data[head];

endmodule

// ==== design/commit_unit.sv ====
module commit_unit #(
  parameter int CB_ENTRIES = 8
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   head_done,
  input  ooo_exec_pkg::reg_idx_t head_rd,
  input  ooo_exec_pkg::word_t    head_data,
  input  logic                   commit_ready,
  output logic                   pop,
  output logic                   commit_valid,
  output ooo_exec_pkg::reg_idx_t commit_rd,
  output ooo_exec_pkg::word_t    commit_data,
  output logic [15:0]            retired_count
);

  logic xfer;

  // tag arithmetic across the units relies on this depth rule
  if (CB_ENTRIES < 4 || (CB_ENTRIES & (CB_ENTRIES - 1)) != 0) begin : g_bad_depth
    $error("completion buffer depth must be a power of two, 4 or more");
  end

  assign xfer = commit_valid && commit_ready;

  // take the head when the output slot is empty or draining now
  assign pop = head_done && (!commit_valid || commit_ready);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      commit_valid  <= 1'b0;
      retired_count <= '0;
    end else begin
      if (pop) begin
        commit_valid <= 1'b1;
      end else if (xfer) begin
        commit_valid <= 1'b0;
      end
      if (xfer) begin
        retired_count <= retired_count + 16'd1;
      end
    end
  end

  // output payload holds until the next pop
  always_ff @(posedge CLK) begin
    if (pop) begin
      commit_rd   <= head_rd;
      commit_data <= head_data;
    end
  end

endmodule

// ==== design/ooo_exec_top.sv ====
module ooo_exec_top #(
  parameter int CB_ENTRIES = ooo_exec_pkg::DEF_CB_ENTRIES
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   issue_valid,
  input  ooo_exec_pkg::exec_op_t issue_op,
  input  ooo_exec_pkg::reg_idx_t issue_rd,
  input  ooo_exec_pkg::word_t    issue_a,
  input  ooo_exec_pkg::word_t    issue_b,
  output logic                   issue_ready,
  output logic                   commit_valid,
  output ooo_exec_pkg::reg_idx_t commit_rd,
  output ooo_exec_pkg::word_t    commit_data,
  input  logic                   commit_ready,
  output logic [15:0]            retired_count
);
  import ooo_exec_pkg::*;

  localparam int TAG_W = $clog2(CB_ENTRIES);

  // allocation and retire handshakes
  logic             full;
  logic             alloc;
  logic [TAG_W-1:0] alloc_tag;
  logic             head_done;
  reg_idx_t         head_rd;
  word_t            head_data;
  logic             pop;

  // shared operand bus to the units
  logic             mul_start;
  logic             div_start;
  logic             div_busy;
  exec_op_t         unit_op;
  word_t            unit_a;
  word_t            unit_b;
  logic [TAG_W-1:0] unit_tag;
  reg_idx_t         unit_rd;

  // writeback ports
  logic             alu_wr_valid;
  logic [TAG_W-1:0] alu_wr_tag;
  reg_idx_t         alu_wr_rd;
  word_t            alu_wr_data;
  logic             mul_wr_valid;
  logic [TAG_W-1:0] mul_wr_tag;
  reg_idx_t         mul_wr_rd;
  word_t            mul_wr_data;
  logic             div_wr_valid;
  logic [TAG_W-1:0] div_wr_tag;
  reg_idx_t         div_wr_rd;
  word_t            div_wr_data;

  issue_unit #(.CB_ENTRIES(CB_ENTRIES)) u_issue (
    .CLK, .nRST, .issue_valid, .issue_op, .issue_rd, .issue_a, .issue_b,
    .full, .alloc_tag, .div_busy, .issue_ready, .alloc, .mul_start, .div_start,
    .unit_op, .unit_a, .unit_b, .unit_tag, .unit_rd,
    .alu_wr_valid, .alu_wr_tag, .alu_wr_rd, .alu_wr_data
  );

  mul_pipe #(.CB_ENTRIES(CB_ENTRIES)) u_mul (
    .CLK, .nRST, .mul_start, .unit_op, .unit_a, .unit_b, .unit_tag, .unit_rd,
    .mul_wr_valid, .mul_wr_tag, .mul_wr_rd, .mul_wr_data
  );

  div_unit #(.CB_ENTRIES(CB_ENTRIES)) u_div (
    .CLK, .nRST, .div_start, .unit_op, .unit_a, .unit_b, .unit_tag, .unit_rd,
    .div_busy, .div_wr_valid, .div_wr_tag, .div_wr_rd, .div_wr_data
  );

  completion_buffer #(.CB_ENTRIES(CB_ENTRIES)) u_cb (
    .CLK, .nRST, .alloc, .pop,
    .alu_wr_valid, .alu_wr_tag, .alu_wr_rd, .alu_wr_data,
    .mul_wr_valid, .mul_wr_tag, .mul_wr_rd, .mul_wr_data,
    .div_wr_valid, .div_wr_tag, .div_wr_rd, .div_wr_data,
    .full, .alloc_tag, .head_done, .head_rd, .head_data
  );

  commit_unit #(.CB_ENTRIES(CB_ENTRIES)) u_commit (
    .CLK, .nRST, .head_done, .head_rd, .head_data, .commit_ready,
    .pop, .commit_valid, .commit_rd, .commit_data, .retired_count
  );

endmodule

// ==== verif/result_checker.sv ====
module result_checker #(
  parameter int MAX_OPS = 64
) (
  input logic                   CLK,
  input logic                   nRST,
  input logic                   issue_ready,
  input logic                   commit_valid,
  input ooo_exec_pkg::reg_idx_t commit_rd,
  input ooo_exec_pkg::word_t    commit_data,
  input logic                   commit_ready,
  input logic [15:0]            retired_count
);
  import ooo_exec_pkg::*;

  // expected results in issue order
  reg_idx_t exp_rd   [MAX_OPS];
  word_t    exp_data [MAX_OPS];
  int       op_count     = 0;
  int       commit_count = 0;
  int       commit_errs  = 0;
  int       other_errs   = 0;

  // reference result per opcode
  function automatic word_t model_result(logic [3:0] op, word_t a, word_t b);
    logic [63:0] prod;
    word_t       r;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      OP_ADD:   r = a + b;
      OP_SUB:   r = a - b;
      OP_AND:   r = a & b;
      OP_OR:    r = a | b;
      OP_XOR:   r = a ^ b;
      OP_SLL:   r = a << b[4:0];
      OP_SRL:   r = a >> b[4:0];
      // on differing sign bits the negative one is smaller
      OP_SLT:   r = (a[31] != b[31]) ? {31'd0, a[31]} : ((a < b) ? 32'd1 : 32'd0);
      OP_MUL:   r = prod[31:0];
      OP_MULHU: r = prod[63:32];
      // divide by zero gives all ones and the dividend back
      OP_DIVU:  r = (b == 32'd0) ? 32'hffff_ffff : a / b;
      OP_REMU:  r = (b == 32'd0) ? a : a % b;
      default:  r = '0;
    endcase
    return r;
  endfunction

  task automatic expect_op(logic [3:0] op, reg_idx_t rd, word_t a, word_t b, word_t listed);
    word_t res;
    res = model_result(op, a, b);
    if (res !== listed) begin
      other_errs++;
      $display("error at %0t: operation %0d model gives %h, input file lists %h",
               $time, op_count, res, listed);
    end
    exp_rd[op_count]   = rd;
    exp_data[op_count] = res;
    op_count++;
  endtask

  // outputs idle while reset is held
  always @(negedge CLK) begin
    if (!nRST) begin
      if (issue_ready !== 1'b0 || commit_valid !== 1'b0 || retired_count !== 16'd0) begin
        other_errs++;
        $display("error at %0t: in reset expected ready 0 valid 0 count 0 got %b %b %0d",
                 $time, issue_ready, commit_valid, retired_count);
      end
    end
  end

  // every transfer must match the next op in file order
  always @(posedge CLK) begin
    if (nRST && commit_valid && commit_ready) begin
      if (commit_count >= op_count) begin
        commit_errs++;
        $display("a commit at %0t has no issued operation left to match", $time);
      end else begin
        if (commit_rd !== exp_rd[commit_count]) begin
          commit_errs++;
          $display("error at %0t: commit %0d rd expected %0d got %0d",
                   $time, commit_count, exp_rd[commit_count], commit_rd);
        end
        if (commit_data !== exp_data[commit_count]) begin
          commit_errs++;
          $display("error at %0t: commit %0d data expected %h got %h",
                   $time, commit_count, exp_data[commit_count], commit_data);
        end
      end
      commit_count++;
    end
  end

  // nothing may be left pending once all ops have transferred
  task automatic check_end(int n_ops);
    if (commit_valid !== 1'b0) begin
      other_errs++;
      $display("error at %0t: commit_valid expected 0 after the last commit got %b",
               $time, commit_valid);
    end
    if (retired_count !== 16'(n_ops)) begin
      other_errs++;
      $display("error at %0t: retired_count expected %0d got %0d",
               $time, n_ops, retired_count);
    end
  endtask

  function automatic int error_total();
    return commit_errs + other_errs;
  endfunction

endmodule

// ==== verif/exec_assert.sv ====
module exec_assert #(
  parameter int CB_ENTRIES = 8
) (
  input logic                          CLK,
  input logic                          nRST,
  input logic [$clog2(CB_ENTRIES):0]   count,
  input logic [CB_ENTRIES-1:0]         ent_busy,
  input logic                          alu_wr_valid,
  input logic [$clog2(CB_ENTRIES)-1:0] alu_wr_tag,
  input logic                          mul_wr_valid,
  input logic [$clog2(CB_ENTRIES)-1:0] mul_wr_tag,
  input logic                          div_wr_valid,
  input logic [$clog2(CB_ENTRIES)-1:0] div_wr_tag,
  input logic                          commit_valid,
  input logic                          commit_ready,
  input logic [4:0]                    commit_rd,
  input logic [31:0]                   commit_data
);

  localparam logic [$clog2(CB_ENTRIES):0] MAX_OCC = ($clog2(CB_ENTRIES)+1)'(CB_ENTRIES);

  // occupancy bound
  a_occupancy: assert property (@(posedge CLK) disable iff (!nRST) count <= MAX_OCC)
    else $error("completion buffer holds more entries than its depth");

  // writebacks only land on allocated slots
  a_alu_wr: assert property (@(posedge CLK) disable iff (!nRST)
    alu_wr_valid |-> ent_busy[alu_wr_tag])
    else $error("alu writeback to a free buffer entry");
  a_mul_wr: assert property (@(posedge CLK) disable iff (!nRST)
    mul_wr_valid |-> ent_busy[mul_wr_tag])
    else $error("multiplier writeback to a free buffer entry");
  a_div_wr: assert property (@(posedge CLK) disable iff (!nRST)
    div_wr_valid |-> ent_busy[div_wr_tag])
    else $error("divider writeback to a free buffer entry");

  // stalled commit keeps valid and payload
  a_commit_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (commit_valid && !commit_ready) |=>
      (commit_valid && $stable(commit_data) && $stable(commit_rd)))
    else $error("commit output changed while stalled");

endmodule

bind ooo_exec_top exec_assert #(.CB_ENTRIES(CB_ENTRIES)) u_exec_assert (
  .CLK(CLK),
  .nRST(nRST),
  .count(u_cb.count),
  .ent_busy(u_cb.ent_busy),
  .alu_wr_valid(alu_wr_valid),
  .alu_wr_tag(alu_wr_tag),
  .mul_wr_valid(mul_wr_valid),
  .mul_wr_tag(mul_wr_tag),
  .div_wr_valid(div_wr_valid),
  .div_wr_tag(div_wr_tag),
  .commit_valid(commit_valid),
  .commit_ready(commit_ready),
  .commit_rd(commit_rd),
  .commit_data(commit_data)
);

// ==== verif/tb_top.sv ====
module tb_top;
  import ooo_exec_pkg::*;

  localparam int    MAX_OPS    = 64;
  localparam string INPUT_FILE = "verif/exec_input.txt";

  logic        CLK;
  logic        nRST;
  logic        issue_valid;
  exec_op_t    issue_op;
  reg_idx_t    issue_rd;
  word_t       issue_a;
  word_t       issue_b;
  logic        issue_ready;
  logic        commit_valid;
  reg_idx_t    commit_rd;
  word_t       commit_data;
  logic        commit_ready;
  logic [15:0] retired_count;

  // operation list from the input file
  logic [3:0]  op_mem [MAX_OPS];
  reg_idx_t    rd_mem [MAX_OPS];
  word_t       a_mem  [MAX_OPS];
  word_t       b_mem  [MAX_OPS];
  int          n_ops;
  int          cycle_limit;
  int          cycles;
  logic        loaded;
  logic [31:0] rng_state;

  ooo_exec_top #(.CB_ENTRIES(DEF_CB_ENTRIES)) i_dut (
    .CLK, .nRST, .issue_valid, .issue_op, .issue_rd, .issue_a, .issue_b,
    .issue_ready, .commit_valid, .commit_rd, .commit_data, .commit_ready,
    .retired_count
  );

  result_checker #(.MAX_OPS(MAX_OPS)) u_chk (
    .CLK, .nRST, .issue_ready, .commit_valid, .commit_rd, .commit_data, .commit_ready,
    .retired_count
  );

  // 32-bit lcg step
  function automatic logic [31:0] next_random(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // one op per line
  // comment lines fail the scan and are skipped
  task automatic load_ops();
    int          fd;
    int          got;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_rd;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_exp;
    n_ops = 0;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("could not open the operation file %s", INPUT_FILE);
    end else begin
      while (!$feof(fd) && n_ops < MAX_OPS) begin
        got = $fgets(line, fd);
        if (got > 0 &&
            $sscanf(line, "%h %h %h %h %h", f_op, f_rd, f_a, f_b, f_exp) == 5) begin
          op_mem[n_ops] = f_op[3:0];
          rd_mem[n_ops] = f_rd[4:0];
          a_mem[n_ops]  = f_a;
          b_mem[n_ops]  = f_b;
          // checker builds its expected list in file order
          u_chk.expect_op(f_op[3:0], f_rd[4:0], f_a, f_b, f_exp);
          n_ops++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // commit back-pressure low about a quarter of the cycles
  initial begin
    rng_state    = 32'hf618_f118;
    commit_ready = 1'b0;
    forever begin
      @(negedge CLK);
      rng_state    = next_random(rng_state);
      commit_ready = (rng_state[31:30] != 2'b00);
    end
  end

  // watchdog sized from the op count
  initial begin
    cycles = 0;
    wait (loaded);
    while (cycles < cycle_limit) begin
      @(posedge CLK);
      cycles++;
    end
    $display("run timed out after %0d cycles with %0d of %0d operations committed",
             cycles, u_chk.commit_count, n_ops);
    $display("errors %0d, commits %0d of %0d", u_chk.error_total(), u_chk.commit_count,
             n_ops);
    $display("test failed");
    $finish;
  end

  initial begin
    int idx;
    nRST        = 1'b0;
    loaded      = 1'b0;
    cycle_limit = 0;
    issue_valid = 1'b0;
    issue_op    = OP_ADD;
    issue_rd    = '0;
    issue_a     = '0;
    issue_b     = '0;
    load_ops();
    if (n_ops == 0) begin
      $display("no operations were read, nothing to run");
      $display("test failed");
      $finish;
    end else begin
      cycle_limit = 40 * n_ops + 100;
      loaded      = 1'b1;
      // reset held for three cycles
      repeat (3) @(negedge CLK);
      nRST = 1'b1;
      // present each op until the edge that accepts it
      idx = 0;
      while (idx < n_ops) begin
        @(negedge CLK);
        issue_valid = 1'b1;
        issue_op    = exec_op_t'(op_mem[idx]);
        issue_rd    = rd_mem[idx];
        issue_a     = a_mem[idx];
        issue_b     = b_mem[idx];
        @(posedge CLK);
        if (issue_ready) begin
          idx++;
        end
      end
      @(negedge CLK);
      issue_valid = 1'b0;
      // drain until every op has transferred
      // retire count settles before the falling edge
      while (u_chk.commit_count < n_ops) begin
        @(negedge CLK);
      end
      u_chk.check_end(n_ops);
      $display("errors %0d, commits %0d of %0d, retired_count %0d", u_chk.error_total(),
               u_chk.commit_count, n_ops, retired_count);
      if (u_chk.error_total() == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

// ==== verif/exec_input.txt ====
# columns: opcode rd operand_a operand_b expected_result, all hex
# opcodes: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt 8 mul 9 mulhu a divu b remu
0 01 00000005 00000007 0000000c
1 02 00000003 00000005 fffffffe
2 03 f0f0ff00 0ff0f0f0 00f0f000
3 04 f0f00000 000f000f f0ff000f
4 05 aaaa5555 ffff0000 55555555
5 06 00000001 00000024 00000010
6 07 80000000 0000003f 00000001
7 08 ffffffff 00000001 00000001
7 09 00000001 ffffffff 00000000
8 0a ffffffff ffffffff 00000001
9 0b ffffffff ffffffff fffffffe
8 0c 00010000 00010000 00000000
9 0d 00010000 00010000 00000001
a 0e 00000064 00000007 0000000e
0 0f 00000001 00000001 00000002
8 10 00000003 00000005 0000000f
b 11 00000064 00000007 00000002
a 12 12345678 00000000 ffffffff
b 13 12345678 00000000 12345678
a 14 ffffffff 00000010 0fffffff
0 15 00000001 00000002 00000003
0 16 00000010 00000020 00000030
4 17 0000ffff 00ff00ff 00ffff00
1 18 00000000 00000001 ffffffff
3 19 00000100 00000001 00000101
5 1a 0000000f 00000008 00000f00
6 1b 0000f000 00000004 00000f00
9 1c 80000000 00000004 00000002
8 1d 00001000 00000100 00100000
7 1e 80000000 7fffffff 00000001
2 1f ffffffff 12345678 12345678
a 00 0000007b 0000000a 0000000c
b 01 0000007b 0000000a 00000003

// ==== project.f ====
design/ooo_exec_pkg.sv
design/issue_unit.sv
design/mul_pipe.sv
design/div_unit.sv
design/completion_buffer.sv
design/commit_unit.sv
design/ooo_exec_top.sv
verif/result_checker.sv
verif/exec_assert.sv
verif/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
